// File: sim/gshare_props.sv
// ~~~~~~~~~~~~~~~~~~~~
// gshare timing properties
// bound into the predictor top level
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module gshare_props import gshare_pkg::*; (
	input logic     clock,
	input logic     reset,
	input logic     clear_en,
	input logic     obq_bh_pred_valid,
	input history_t obq_gh_in,
	input history_t ght_out,
	input logic     prediction_valid,
	input logic     prediction_out
);

	int fail_count = 0; // read by the testbench summary

	// a rollback cycle never carries a usable prediction
	valid_off_on_clear: assert property (@(posedge clock) disable iff (reset)
		clear_en |-> !prediction_valid)
		else begin $error("prediction_valid high while clear_en is high"); fail_count++; end

	// no valid, no taken guess
	pred_needs_valid: assert property (@(posedge clock) disable iff (reset)
		!prediction_valid |-> !prediction_out)
		else begin $error("prediction_out high without prediction_valid"); fail_count++; end

	// restore lands one edge after the rollback
	rollback_restores: assert property (@(posedge clock) disable iff (reset)
		(clear_en && obq_bh_pred_valid) |=> (ght_out == $past(obq_gh_in)))
		else begin $error("ght_out not restored from obq_gh_in"); fail_count++; end

	// sync reset clears the history
	reset_clears_history: assert property (@(posedge clock)
		reset |=> (ght_out == '0))
		else begin $error("ght_out not zero after reset"); fail_count++; end

endmodule

bind gshare_top gshare_props u_props (
	.clock             (clock),
	.reset             (reset),
	.clear_en          (clear_en),
	.obq_bh_pred_valid (obq_bh_pred_valid),
	.obq_gh_in         (obq_gh_in),
	.ght_out           (ght_out),
	.prediction_valid  (prediction_valid),
	.prediction_out    (prediction_out)
);

// File: sim/gshare_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// gshare predictor testbench
// directed and random stimulus checked against a bit level model
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_consts.svh"

module gshare_tb import gshare_pkg::*; ();

	localparam int CLK_PERIOD    = 100;
	localparam int RESET_CYCLES  = 16;
	localparam int RANDOM_CYCLES = 2000;
	localparam int TEST_CYCLES   = RESET_CYCLES + 150 + RANDOM_CYCLES; // directed part stays under 150
	localparam int MARGIN        = 200;

	logic     clock = 1'b0;
	logic     reset;
	logic     enable;
	logic     if_branch;
	pc_t      pc_in;
	logic     obq_bh_pred_valid;
	history_t obq_gh_in;
	logic     clear_en;
	pc_t      rt_pc;
	history_t ght_out;
	logic     prediction_valid;
	logic     prediction_out;

	logic     m_table [1 << `BH_SIZE]; // reference pattern table
	history_t m_ght;                   // reference history
	history_t upd_idx;                 // model update index
	history_t exp_idx;                 // checker lookup index
	logic     exp_lookup;
	logic     exp_pred;
	logic     exp_valid;
	int       checks = 0;
	int       errors = 0;
	int       test_start_errors = 0;
	int       tests_passed = 0;
	int       tests_failed = 0;

	gshare_top DUT (
		.clock             (clock),
		.reset             (reset),
		.enable            (enable),
		.if_branch         (if_branch),
		.pc_in             (pc_in),
		.obq_bh_pred_valid (obq_bh_pred_valid),
		.obq_gh_in         (obq_gh_in),
		.clear_en          (clear_en),
		.rt_pc             (rt_pc),
		.ght_out           (ght_out),
		.prediction_valid  (prediction_valid),
		.prediction_out    (prediction_out)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// model steps on the same edge as the DUT, inputs still hold the old cycle
	always @(posedge clock) begin
		if (reset) begin
			foreach (m_table[i]) m_table[i] = 1'b0;
			m_ght = '0;
		end else if (clear_en && obq_bh_pred_valid) begin
			upd_idx = obq_gh_in ^ rt_pc[`PC_SIZE+1:2]; // entry of the bad branch
			m_table[upd_idx] = ~m_table[upd_idx];
			m_ght = obq_gh_in;
		end else if (enable && if_branch && !clear_en) begin
			upd_idx = m_ght ^ pc_in[`PC_SIZE+1:2];
			m_ght = {m_ght[`BH_SIZE-2:0], m_table[upd_idx]};
		end
	end

	// outputs are settled mid cycle
	always @(negedge clock) begin
		if (!reset) begin
			exp_idx    = m_ght ^ pc_in[`PC_SIZE+1:2];
			exp_lookup = enable & if_branch & ~clear_en;
			exp_pred   = exp_lookup & m_table[exp_idx];
			exp_valid  = if_branch & ~clear_en; // valid ignores enable
			checks += 3;
			assert (ght_out === m_ght) else begin
				$display("ERROR %0t ns ght_out got %h expected %h", $time, ght_out, m_ght);
				errors++;
			end
			assert (prediction_out === exp_pred) else begin
				$display("ERROR %0t ns prediction_out got %b expected %b",
					$time, prediction_out, exp_pred);
				errors++;
			end
			assert (prediction_valid === exp_valid) else begin
				$display("ERROR %0t ns prediction_valid got %b expected %b",
					$time, prediction_valid, exp_valid);
				errors++;
			end
		end
	end

	task automatic drive_cycle(input logic en, input logic br, input pc_t pc,
		input logic clr, input logic vld, input history_t gh, input pc_t rpc);
		@(posedge clock);
		enable            <= en;
		if_branch         <= br;
		pc_in             <= pc;
		clear_en          <= clr;
		obq_bh_pred_valid <= vld;
		obq_gh_in         <= gh;
		rt_pc             <= rpc;
	endtask

	task automatic lookup_branch(input pc_t pc);
		drive_cycle(1'b1, 1'b1, pc, 1'b0, 1'b0, '0, '0);
	endtask

	task automatic rollback(input history_t gh, input pc_t rpc);
		drive_cycle(1'b0, 1'b0, '0, 1'b1, 1'b1, gh, rpc);
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, '0, '0);
	endtask

	// direct look at the cycle just driven
	task automatic expect_prediction(input logic exp);
		@(negedge clock);
		checks++;
		assert (prediction_out === exp) else begin
			$display("ERROR %0t ns prediction_out got %b expected %b", $time, prediction_out, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		int new_errors;
		idle_cycle();
		@(posedge clock); // last negedge check is done by now
		new_errors = errors - test_start_errors;
		test_start_errors = errors;
		if (new_errors == 0) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, new_errors);
		end
	endtask

	// rollback then hit the same entry, bank picked by the low hash bits
	task automatic flip_bank_entry(input int bank);
		history_t g;
		pc_t      r;
		// entry must still be not taken, so the first flip reads taken
		do begin
			g = $urandom;
			r = $urandom;
			r[3:2] = g[1:0] ^ bank[1:0];
		end while (m_table[g ^ r[`PC_SIZE+1:2]] != 1'b0);
		rollback(g, r);
		lookup_branch(r);
		expect_prediction(1'b1);
		rollback(g, r); // second flip undoes the first
		lookup_branch(r);
		expect_prediction(1'b0);
	endtask

	initial begin
		history_t g;
		pc_t      r;
		int       kind;
		void'($urandom(74685));
		reset = 1'b1;
		enable = 1'b0;
		if_branch = 1'b0;
		pc_in = '0;
		obq_bh_pred_valid = 1'b0;
		obq_gh_in = '0;
		clear_en = 1'b0;
		rt_pc = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		// zero history, sweep consecutive words over all banks
		for (int i = 0; i < 16; i++) lookup_branch(pc_t'(i << 2));
		end_test("reset");

		// set a few entries so taken bits get shifted in too
		for (int k = 0; k < 8; k++) begin
			g = $urandom;
			r = $urandom;
			rollback(g, r);
			lookup_branch(r);
			repeat (3) lookup_branch($urandom);
		end
		end_test("history shift");

		for (int b = 0; b < `NUM_BANKS; b++) flip_bank_entry(b);
		end_test("rollback and flip");

		repeat (4) drive_cycle(1'b0, 1'b1, $urandom, 1'b0, 1'b0, '0, '0); // disabled lookups
		repeat (4) drive_cycle(1'b1, 1'b1, $urandom, 1'b1, 1'b0, $urandom, $urandom);
		end_test("idle and partial");

		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			kind = $urandom_range(9);
			if (kind < 6) begin
				drive_cycle($urandom_range(7) != 0, 1'b1, $urandom, 1'b0,
					$urandom_range(1), $urandom, $urandom);
			end else if (kind < 8) begin
				drive_cycle($urandom_range(1), $urandom_range(1), $urandom, 1'b1,
					$urandom_range(3) != 0, $urandom, $urandom);
			end else begin
				drive_cycle($urandom_range(1), 1'b0, $urandom, 1'b0, 1'b0, $urandom, $urandom);
			end
		end
		end_test("random mix");

		errors += DUT.u_props.fail_count; // property failures count as well
		$display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
			tests_passed, tests_failed, checks, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// watchdog sized from the test lengths
	initial begin
		#((TEST_CYCLES + MARGIN) * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
		$display("TB FAILED");
		$finish;
	end

endmodule

// File: src.f
+incdir+verilog
verilog/gshare_pkg.sv
verilog/pht_if.sv
verilog/gshare_hash.sv
verilog/pht_bank.sv
verilog/global_history.sv
verilog/gshare_top.sv
sim/gshare_props.sv
sim/gshare_tb.sv

// File: verilog/global_history.sv
// ~~~~~~~~~~~~~~~~~~~~
// global history unit
// picks the predicted bit and shifts or restores the history
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_consts.svh"

module global_history import gshare_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [`NUM_BANKS-1:0] bank_bits,     // read bit of each bank
	input  history_t              obq_gh_in,     // history to restore on rollback
	pht_if.history_side           pht,           // lookup and flip levels
	output history_t              ght,           // current global history
	output logic                  prediction_out // 1 taken, 0 not taken
);

	logic sel_bit; // entry of the addressed bank

	// bank mux, indexed by the low hash bits
	assign sel_bit = bank_bits[pht.lookup_bank];

	// no lookup, no taken guess
	assign prediction_out = pht.lookup_en & sel_bit;

	// flip and lookup never overlap, lookup is blocked by clear_en
	always_ff @(posedge clock) begin
		if (reset) begin
			ght <= '0;
		end else if (pht.flip_en) begin
			ght <= obq_gh_in; // undo everything after the bad branch
		end else if (pht.lookup_en) begin
			ght <= {ght[`BH_SIZE-2:0], prediction_out}; // speculative shift
		end
	end

endmodule

// File: verilog/gshare_consts.svh
// ~~~~~~~~~~~~~~~~~~~~
// gshare predictor constants
// history length, hashed pc bits and pattern table banking
// ~~~~~~~~~~~~~~~~~~~~
`ifndef GSHARE_CONSTS_SVH
`define GSHARE_CONSTS_SVH

// global history length, also the full table index width
`define BH_SIZE 10

// pc word bits hashed against the history
// taken from bit 2 upward, byte offset is dropped
`define PC_SIZE `BH_SIZE

// low index bits that pick the bank
`define BANK_BITS 2

// number of table banks
`define NUM_BANKS (1 << `BANK_BITS)

// one bit entries held by each bank
`define BANK_DEPTH (1 << (`BH_SIZE - `BANK_BITS))

`endif

// File: verilog/gshare_hash.sv
// ~~~~~~~~~~~~~~~~~~~~
// gshare hash unit
// xors history with pc word bits and splits the index by bank
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_consts.svh"

module gshare_hash import gshare_pkg::*; (
	input  logic     enable,            // predictor on
	input  logic     if_branch,         // fetched instruction is a branch
	input  pc_t      pc_in,             // fetch pc
	input  logic     clear_en,          // misprediction seen at retire
	input  logic     obq_bh_pred_valid, // branch queue holds a saved entry
	input  history_t obq_gh_in,         // history saved with the bad branch
	input  pc_t      rt_pc,             // pc of the bad branch
	input  history_t ght,               // current global history
	output logic     prediction_valid,  // fetch may use the prediction
	pht_if.hash_side pht                // requests to banks and history
);

	history_t pc_word;      // fetch pc without byte offset
	history_t rt_word;      // retire pc without byte offset
	history_t lookup_index; // full table index for the fetch branch
	history_t flip_index;   // full table index for the rollback

	// byte offset bits 1:0 never reach the hash
	assign pc_word = pc_in[`PC_SIZE+1:2];
	assign rt_word = rt_pc[`PC_SIZE+1:2];

	// gshare hash, history xor pc
	assign lookup_index = ght ^ pc_word;

	// rollback uses the saved history, the same one the branch was predicted with
	assign flip_index = obq_gh_in ^ rt_word;

	// low bits pick the bank so neighbouring words spread over banks
	assign pht.lookup_bank = lookup_index[`BANK_BITS-1:0];
	assign pht.lookup_idx  = lookup_index[`BH_SIZE-1:`BANK_BITS];
	assign pht.flip_bank   = flip_index[`BANK_BITS-1:0];
	assign pht.flip_idx    = flip_index[`BH_SIZE-1:`BANK_BITS];

	// lookup only when no rollback is in flight
	assign pht.lookup_en = enable & if_branch & ~clear_en;

	// clear_en alone does nothing without a saved queue entry
	assign pht.flip_en = clear_en & obq_bh_pred_valid;

	// valid does not depend on enable, a disabled predictor
	// reports a valid not taken guess
	assign prediction_valid = if_branch & ~clear_en;

endmodule

// File: verilog/gshare_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// gshare predictor types
// plain vector typedefs for history, pc and bank addressing
// ~~~~~~~~~~~~~~~~~~~~
`include "gshare_consts.svh"

package gshare_pkg;

	// global history register, same width as a full table index
	typedef logic [`BH_SIZE-1:0] history_t;

	// fetch or retire program counter
	typedef logic [31:0] pc_t;

	// bank number, taken from the low index bits
	typedef logic [`BANK_BITS-1:0] bank_sel_t;

	// entry address inside one bank, the upper index bits
	typedef logic [`BH_SIZE-`BANK_BITS-1:0] bank_idx_t;

endpackage

// File: verilog/gshare_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// gshare branch predictor
// hash unit, banked pattern table and global history
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_consts.svh"

module gshare_top import gshare_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     enable,            // predictor on
	input  logic     if_branch,         // fetched instruction is a branch
	input  pc_t      pc_in,             // fetch pc
	input  logic     obq_bh_pred_valid, // branch queue not empty
	input  history_t obq_gh_in,         // saved history of the bad branch
	input  logic     clear_en,          // misprediction, roll back
	input  pc_t      rt_pc,             // pc of the bad branch
	output history_t ght_out,           // global history
	output logic     prediction_valid,  // prediction usable this cycle
	output logic     prediction_out     // predicted direction
);

	logic [`NUM_BANKS-1:0] bank_bits; // one read bit per bank

	pht_if pht (); // hash requests fanned out to banks and history

	// index generation and valid
	gshare_hash u_hash (
		.enable            (enable),
		.if_branch         (if_branch),
		.pc_in             (pc_in),
		.clear_en          (clear_en),
		.obq_bh_pred_valid (obq_bh_pred_valid),
		.obq_gh_in         (obq_gh_in),
		.rt_pc             (rt_pc),
		.ght               (ght_out),
		.prediction_valid  (prediction_valid),
		.pht               (pht.hash_side)
	);

	// banks share the in-bank index, each one checks its own flip
	genvar b;
	generate
		for (b = 0; b < `NUM_BANKS; b++) begin : g_bank
			pht_bank #(
				.BANK_ID (bank_sel_t'(b))
			) u_bank (
				.clock    (clock),
				.reset    (reset),
				.pht      (pht.bank_side),
				.read_bit (bank_bits[b])
			);
		end
	endgenerate

	// bank mux and history register
	global_history u_history (
		.clock          (clock),
		.reset          (reset),
		.bank_bits      (bank_bits),
		.obq_gh_in      (obq_gh_in),
		.pht            (pht.history_side),
		.ght            (ght_out),
		.prediction_out (prediction_out)
	);

endmodule

// File: verilog/pht_bank.sv
// ~~~~~~~~~~~~~~~~~~~~
// pattern history table bank
// one bit direction entries, combinational read, flip on rollback
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "gshare_consts.svh"

module pht_bank import gshare_pkg::*; #(
	parameter bank_sel_t BANK_ID = '0 // bank number matched against flip_bank
) (
	input  logic     clock,
	input  logic     reset,
	pht_if.bank_side pht,     // lookup and flip requests
	output logic     read_bit // entry at lookup_idx, 1 is taken
);

	logic [`BANK_DEPTH-1:0] entries; // one direction bit per entry
	logic                   flip_hit; // rollback targets this bank

	// every bank presents its entry, the history unit picks one
	assign read_bit = entries[pht.lookup_idx];

	assign flip_hit = pht.flip_en & (pht.flip_bank == BANK_ID);

	// a one bit predictor just inverts on a misprediction
	always_ff @(posedge clock) begin
		if (reset) begin
			entries <= '0; // all not taken
		end else if (flip_hit) begin
			entries[pht.flip_idx] <= ~entries[pht.flip_idx];
		end
	end

endmodule

// File: verilog/pht_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// pattern table request bundle
// lookup and flip requests from the hash unit to banks and history
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface pht_if import gshare_pkg::*; ();

	logic      lookup_en;   // branch lookup this cycle
	bank_sel_t lookup_bank; // bank holding the lookup entry
	bank_idx_t lookup_idx;  // entry within that bank
	logic      flip_en;     // rollback, invert one entry
	bank_sel_t flip_bank;   // bank holding the mispredicted entry
	bank_idx_t flip_idx;    // entry to invert

	// hash unit owns every request signal
	modport hash_side (
		output lookup_en, lookup_bank, lookup_idx,
		output flip_en, flip_bank, flip_idx
	);

	// all banks read at the same in-bank index, bank select happens later
	modport bank_side (
		input lookup_idx,
		input flip_en, flip_bank, flip_idx
	);

	// history unit picks the bank bit and decides shift or restore
	modport history_side (
		input lookup_en, lookup_bank,
		input flip_en
	);

endinterface
